// File: run.sh
#!/bin/sh
# build the PRBS testbench with Verilator and run it from the project root
set -e
cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal --top-module prbsTb -f tb.f
./obj_dir/VprbsTb | tee sim.log

if grep -q "Verification passed" sim.log; then
  echo "simulation result: pass"
else
  echo "simulation result: fail"
  exit 1
fi

// File: src/errorCounter.sv
`timescale 1ns/1ps

module errorCounter (
  input  logic                            clk,
  input  logic                            nreset,
  input  logic                            inc,
  input  logic                            statReq,
  output logic                            statAck,
  output logic [prbsPkg::COUNT_WIDTH-1:0] statCount
);
  import prbsPkg::*;

  logic [COUNT_WIDTH-1:0] count;
  logic                   snapshot;
  logic                   atMax;

  // a request is served only once the previous ack has dropped
  assign snapshot = statReq & ~statAck;

  // the count sticks at all ones instead of wrapping to zero
  assign atMax = &count;

  // ----------------------------------------------------------------------
  // error count
  // ----------------------------------------------------------------------

  // on a snapshot the count restarts, but an error pulse arriving in the
  // same cycle belongs to the new interval and starts it at one
  always_ff @(posedge clk or negedge nreset) begin
    if (!nreset) begin
      count <= '0;
    end else if (snapshot) begin
      count <= inc ? COUNT_WIDTH'(1) : '0;
    end else if (inc && !atMax) begin
      count <= count + 1'b1;
    end
  end

  // ----------------------------------------------------------------------
  // four-phase readout
  // ----------------------------------------------------------------------

  // statCount holds the value of the last snapshot until the next one
  always_ff @(posedge clk or negedge nreset) begin
    if (!nreset) begin
      statCount <= '0;
    end else if (snapshot) begin
      statCount <= count;
    end
  end

  // ack rises with the snapshot and stays up as long as the host holds req
  // once req falls, ack follows on the next edge and the link is ready again
  always_ff @(posedge clk or negedge nreset) begin
    if (!nreset) begin
      statAck <= 1'b0;
    end else if (snapshot) begin
      statAck <= 1'b1;
    end else if (!statReq) begin
      statAck <= 1'b0;
    end
  end

  // the host samples statCount while ack is high, it is stable the whole
  // time since a new snapshot needs ack low first

  // errors keep counting during the whole handshake, only the snapshot
  // cycle itself restarts the count

endmodule

// File: src/prbsChecker.sv
`timescale 1ns/1ps

module prbsChecker (
  input  logic                           clk,
  input  logic                           nreset,
  input  logic                           enable,
  input  logic [prbsPkg::PAT_WIDTH-1:0]  patternSel,
  input  logic                           pause,
  input  logic [prbsPkg::DATA_WIDTH-1:0] rxData,
  output logic                           lock,
  output logic                           errorFlag
);
  import prbsPkg::*;

  logic [STATE_WIDTH-1:0] state;
  logic [MATCH_WIDTH-1:0] matchCount;
  logic [PAT_WIDTH-1:0]   patLatch;
  logic [DATA_WIDTH-1:0]  predReg;
  logic [DATA_WIDTH-1:0]  predCurr;
  logic [DATA_WIDTH-1:0]  predNext;
  logic                   active;
  logic                   wordMatch;
  logic                   seedSeen;
  logic                   countReached;

  // a paused cycle carries no new word, so nothing is compared or advanced
  assign active = enable & ~pause;

  // predReg holds the word expected in the current cycle
  assign wordMatch = (rxData == predReg);

  assign seedSeen     = active && (state == ST_IDLE) && (rxData == SEED);
  assign countReached = (matchCount > MATCH_WIDTH'(LOCK_CYCLES));

  // until lock the prediction follows the received data, after that it
  // runs free from its own register so a bad word cannot disturb it
  assign predCurr = (state == ST_LOCKED) ? predReg : rxData;

  assign lock = (state == ST_LOCKED);

  // ----------------------------------------------------------------------
  // receive FSM
  // ----------------------------------------------------------------------

  // there is no way back from locked except through disable
  always_ff @(posedge clk or negedge nreset) begin
    if (!nreset) begin
      state <= ST_IDLE;
    end else if (!enable) begin
      state <= ST_IDLE;
    end else begin
      case (state)
        ST_IDLE: begin
          if (seedSeen) begin
            state <= ST_LOCKING;
          end
        end
        ST_LOCKING: begin
          if (countReached) begin
            state <= ST_LOCKED;
          end
        end
        ST_LOCKED: begin
          state <= ST_LOCKED;
        end
        default: begin
          state <= ST_IDLE;
        end
      endcase
    end
  end

  // the pattern is taken while the link is idle, same as the generator
  always_ff @(posedge clk or negedge nreset) begin
    if (!nreset) begin
      patLatch <= PAT7;
    end else if (!enable) begin
      patLatch <= patternSel;
    end
  end

  // ----------------------------------------------------------------------
  // match counting and prediction
  // ----------------------------------------------------------------------

  // the seed word counts as the first match, so with clean data the count
  // passes LOCK_CYCLES 32 words after the seed and lock follows one later
  always_ff @(posedge clk or negedge nreset) begin
    if (!nreset) begin
      matchCount <= '0;
    end else if (state == ST_IDLE) begin
      matchCount <= seedSeen ? MATCH_WIDTH'(1) : '0;
    end else if ((state == ST_LOCKING) && active) begin
      matchCount <= wordMatch ? matchCount + 1'b1 : '0;
    end
  end

  always_ff @(posedge clk) begin
    if (!pause) begin
      predReg <= predNext;
    end
  end

  // one pulse per bad word, one cycle after it, and only while locked
  always_ff @(posedge clk or negedge nreset) begin
    if (!nreset) begin
      errorFlag <= 1'b0;
    end else begin
      errorFlag <= active && (state == ST_LOCKED) && !wordMatch;
    end
  end

  prbsPoly u_poly (
    .word       (predCurr),
    .patternSel (patLatch),
    .nextWord   (predNext)
  );

endmodule

// File: src/prbsGenerator.sv
`timescale 1ns/1ps

module prbsGenerator (
  input  logic                           clk,
  input  logic                           nreset,
  input  logic                           enable,
  input  logic [prbsPkg::PAT_WIDTH-1:0]  patternSel,
  input  logic                           pause,
  input  logic                           insertError,
  output logic [prbsPkg::DATA_WIDTH-1:0] txData
);
  import prbsPkg::*;

  logic [PAT_WIDTH-1:0]  patLatch;
  logic [DATA_WIDTH-1:0] seqReg;
  logic [DATA_WIDTH-1:0] seqNext;
  logic                  advance;

  // a word goes out on every enabled cycle that is not paused
  assign advance = enable & ~pause;

  // ----------------------------------------------------------------------
  // pattern and sequence state
  // ----------------------------------------------------------------------

  // the pattern can only change while the link is idle
  always_ff @(posedge clk or negedge nreset) begin
    if (!nreset) begin
      patLatch <= PAT7;
    end else if (!enable) begin
      patLatch <= patternSel;
    end
  end

  // seqReg holds the word that goes out on the next advance
  // while disabled it sits at the seed so the first word after enable is SEED
  always_ff @(posedge clk or negedge nreset) begin
    if (!nreset) begin
      seqReg <= SEED;
    end else if (!enable) begin
      seqReg <= SEED;
    end else if (!pause) begin
      seqReg <= seqNext;
    end
  end

  // ----------------------------------------------------------------------
  // transmit register
  // ----------------------------------------------------------------------

  // txData is zero while idle and holds its word through a pause
  // an error flips bit 0 of the outgoing word only, seqReg keeps the clean
  // sequence so the stream carries on as if nothing happened
  always_ff @(posedge clk or negedge nreset) begin
    if (!nreset) begin
      txData <= '0;
    end else if (!enable) begin
      txData <= '0;
    end else if (advance) begin
      txData <= {seqReg[DATA_WIDTH-1:1], seqReg[0] ^ insertError};
    end
  end

  prbsPoly u_poly (
    .word       (seqReg),
    .patternSel (patLatch),
    .nextWord   (seqNext)
  );

endmodule

// File: src/prbsPkg.sv
package prbsPkg;

  // ----------------------------------------------------------------------
  // data path and counter widths
  // ----------------------------------------------------------------------

  localparam int DATA_WIDTH  = 32;
  localparam int COUNT_WIDTH = 16;
  localparam int PAT_WIDTH   = 2;

  // ----------------------------------------------------------------------
  // pattern select codes and their tap tables
  // ----------------------------------------------------------------------

  localparam logic [PAT_WIDTH-1:0] PAT7  = 2'd0;
  localparam logic [PAT_WIDTH-1:0] PAT10 = 2'd1;
  localparam logic [PAT_WIDTH-1:0] PAT23 = 2'd2;
  localparam logic [PAT_WIDTH-1:0] PAT31 = 2'd3;
  localparam int                   PAT_COUNT = 4;

  // polynomial order and feedback tap, indexed by the pattern code above
  // a new bit is the XOR of the bits TAP_HI and TAP_LO places back in the stream
  localparam int TAP_HI [PAT_COUNT] = '{7, 10, 23, 31};
  localparam int TAP_LO [PAT_COUNT] = '{6, 7, 18, 28};

  // ----------------------------------------------------------------------
  // sequence start and lock detection
  // ----------------------------------------------------------------------

  // first word on the link after enable, must not be zero
  localparam logic [DATA_WIDTH-1:0] SEED = 32'h0000_0061;

  // lock once the match count goes past this value
  localparam int LOCK_CYCLES = 31;
  localparam int MATCH_WIDTH = $clog2(LOCK_CYCLES + 2);

  // receive FSM encoding
  localparam int                     STATE_WIDTH = 2;
  localparam logic [STATE_WIDTH-1:0] ST_IDLE     = 2'd0;
  localparam logic [STATE_WIDTH-1:0] ST_LOCKING  = 2'd1;
  localparam logic [STATE_WIDTH-1:0] ST_LOCKED   = 2'd2;

endpackage

// File: src/prbsPoly.sv
`timescale 1ns/1ps

module prbsPoly (
  input  logic [prbsPkg::DATA_WIDTH-1:0] word,
  input  logic [prbsPkg::PAT_WIDTH-1:0]  patternSel,
  output logic [prbsPkg::DATA_WIDTH-1:0] nextWord
);
  import prbsPkg::*;

  // ----------------------------------------------------------------------
  // tap selection
  // ----------------------------------------------------------------------

  // order and feedback tap of the selected polynomial
  int tapHi;
  int tapLo;

  assign tapHi = TAP_HI[patternSel];
  assign tapLo = TAP_LO[patternSel];

  // ----------------------------------------------------------------------
  // parallel step
  // ----------------------------------------------------------------------

  // the word is a window on the serial stream with the oldest bit in the MSB,
  // so bit 0 is the newest bit and the bit k places back sits at index k-1

  // each pass of the loop is one serial clock of the LFSR: compute the new
  // bit from the two taps, shift it in at the bottom and drop the oldest bit

  // after DATA_WIDTH passes the window holds exactly the next word, again
  // with its oldest bit in the MSB

  // every tap is below DATA_WIDTH so the window always holds both taps
  always_comb begin
    logic [DATA_WIDTH-1:0] window;
    logic                  newBit;

    window = word;
    for (int i = 0; i < DATA_WIDTH; i++) begin
      newBit = window[tapHi-1] ^ window[tapLo-1];
      window = {window[DATA_WIDTH-2:0], newBit};
    end
    nextWord = window;
  end

  // a synthesis tool folds the loop into one XOR network per bit, with the
  // tap pair chosen by a small mux in front of each network

  // the same function serves the generator and the checker, so both ends of
  // the link agree on the stream by construction

  // with an all-zero word the output stays zero, which is why the seed is
  // nonzero

  // for PRBS31 only the newest 31 bits of the word set the next word, so the
  // MSB of the word drops out of the sequence after one step

  // a shorter pattern uses even fewer bits of the window, the rest are just
  // carried along and shifted out

endmodule

// File: src/prbsTop.sv
`timescale 1ns/1ps

module prbsTop (
  input  logic                            clk,
  input  logic                            nreset,
  input  logic                            enable,
  input  logic [prbsPkg::PAT_WIDTH-1:0]   patternSel,
  input  logic                            pause,
  input  logic                            insertError,
  output logic [prbsPkg::DATA_WIDTH-1:0]  txData,
  input  logic [prbsPkg::DATA_WIDTH-1:0]  rxData,
  output logic                            lock,
  output logic                            errorFlag,
  input  logic                            statReq,
  output logic                            statAck,
  output logic [prbsPkg::COUNT_WIDTH-1:0] statCount
);

  // ----------------------------------------------------------------------
  // transmit side
  // ----------------------------------------------------------------------

  prbsGenerator u_gen (
    .clk         (clk),
    .nreset      (nreset),
    .enable      (enable),
    .patternSel  (patternSel),
    .pause       (pause),
    .insertError (insertError),
    .txData      (txData)
  );

  // ----------------------------------------------------------------------
  // receive side
  // ----------------------------------------------------------------------

  // enable, patternSel and pause are shared with the generator so both
  // ends step through the same pattern in lockstep
  prbsChecker u_chk (
    .clk        (clk),
    .nreset     (nreset),
    .enable     (enable),
    .patternSel (patternSel),
    .pause      (pause),
    .rxData     (rxData),
    .lock       (lock),
    .errorFlag  (errorFlag)
  );

  // each errorFlag cycle adds one to the count
  errorCounter u_cnt (
    .clk       (clk),
    .nreset    (nreset),
    .inc       (errorFlag),
    .statReq   (statReq),
    .statAck   (statAck),
    .statCount (statCount)
  );

endmodule

// File: tb.f
src/prbsPkg.sv
src/prbsPoly.sv
src/prbsGenerator.sv
src/prbsChecker.sv
src/errorCounter.sv
src/prbsTop.sv
verif/prbsTb_checker.sv
verif/prbsTb.sv

// File: verif/prbsTb.sv
`timescale 1ns/1ps

module prbsTb;
  import prbsPkg::*;

  // the six tests run for about 2500 cycles together
  localparam int TIMEOUT_CYCLES = 4000;
  localparam int PATTERN_WORDS  = 300;
  localparam int PAUSE_CYCLES   = 600;
  localparam int LOCK_WORDS     = 33;
  localparam int ERROR_WORDS    = 12;
  localparam int WAIT_LIMIT     = 16;

  logic                   clk;
  logic                   nreset;
  logic                   enable;
  logic [PAT_WIDTH-1:0]   patternSel;
  logic                   pause;
  logic                   insertError;
  logic [DATA_WIDTH-1:0]  txData;
  logic [DATA_WIDTH-1:0]  rxData;
  logic [DATA_WIDTH-1:0]  corruptMask;
  logic                   lock;
  logic                   errorFlag;
  logic                   statReq;
  logic                   statAck;
  logic [COUNT_WIDTH-1:0] statCount;

  int    seed        = 32'hdefb;
  int    errorCount  = 0;
  int    testErrors  = 0;
  int    testsRun    = 0;
  int    testsFailed = 0;
  int    cycleCount  = 0;
  string testName    = "reset";

  // loopback path, a set bit in the mask flips that bit of the received word
  assign rxData = txData ^ corruptMask;

  prbsTop u_dut (.*);

  bind prbsTop prbsTb_checker u_checker (
    .clk (clk), .nreset (nreset), .enable (enable), .lock (lock),
    .errorFlag (errorFlag), .statReq (statReq), .statAck (statAck)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // ----------------------------------------------------------------------
  // reference model and reporting
  // ----------------------------------------------------------------------

  // hist holds the current word in its upper half with the oldest bit on top
  // and the next word is filled in below it, one stream bit at a time
  function automatic logic [DATA_WIDTH-1:0] prbsNext(input logic [DATA_WIDTH-1:0] word,
                                                     input logic [PAT_WIDTH-1:0] pattern);
    logic [2*DATA_WIDTH-1:0] hist;
    int                      hi;
    int                      lo;
    hi = (pattern == PAT7) ? 7 : (pattern == PAT10) ? 10 : (pattern == PAT23) ? 23 : 31;
    lo = (pattern == PAT7) ? 6 : (pattern == PAT10) ? 7 : (pattern == PAT23) ? 18 : 28;
    hist = {word, {DATA_WIDTH{1'b0}}};
    for (int p = DATA_WIDTH - 1; p >= 0; p--) begin
      hist[p] = hist[p + hi] ^ hist[p + lo];
    end
    return hist[DATA_WIDTH-1:0];
  endfunction

  task automatic checkValue(input string what, input logic [31:0] expected,
                            input logic [31:0] actual);
    assert (actual === expected) else begin
      $display("FAILED %s (%s): expected %h, actual %h", testName, what, expected, actual);
      errorCount++;
    end
  endtask

  task automatic expectTrue(input bit cond, input string what);
    assert (cond) else begin
      $display("ERROR in %s: %s did not hold", testName, what);
      errorCount++;
    end
  endtask

  task automatic beginTest(input string name);
    testName = name;
    testErrors = errorCount;
  endtask

  task automatic endTest();
    // the generator model compares on the same falling edge, so the tally
    // waits for the rising edge after it
    @(posedge clk);
    testsRun++;
    if (errorCount == testErrors) begin
      $display("test %s: ok", testName);
    end else begin
      testsFailed++;
      $display("test %s: %0d failed checks", testName, errorCount - testErrors);
    end
  endtask

  // generator model, stepped from the inputs seen in the previous cycle
  logic [DATA_WIDTH-1:0] modelSeq   = SEED;
  logic [DATA_WIDTH-1:0] modelTx    = '0;
  logic [PAT_WIDTH-1:0]  modelPat   = PAT7;
  logic                  lastEnable = 1'b0;
  logic                  lastPause  = 1'b0;
  logic                  lastInsert = 1'b0;

  always @(negedge clk) begin
    if (!lastEnable) begin
      modelTx = '0;
      modelSeq = SEED;
    end else if (!lastPause) begin
      modelTx = modelSeq ^ DATA_WIDTH'(lastInsert);
      modelSeq = prbsNext(modelSeq, modelPat);
    end
    if (nreset) begin
      checkValue("txData", modelTx, txData);
    end
    if (!nreset) begin
      modelPat = PAT7;
    end else if (!enable) begin
      modelPat = patternSel;
    end
    lastEnable = nreset && enable;
    lastPause = pause;
    lastInsert = insertError;
  end

  always @(posedge clk) begin
    cycleCount++;
    if (cycleCount >= TIMEOUT_CYCLES) begin
      $display("ERROR: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Verification failed");
      $finish;
    end
  end

  // ----------------------------------------------------------------------
  // stimulus tasks
  // ----------------------------------------------------------------------

  // returns at the falling edge of the cycle that carries the seed word
  task automatic startLink(input logic [PAT_WIDTH-1:0] pattern);
    @(posedge clk);
    enable <= 1'b0;
    patternSel <= pattern;
    repeat (2) @(posedge clk);
    enable <= 1'b1;
    @(posedge clk);
    @(negedge clk);
    checkValue("first word", SEED, txData);
  endtask

  // one bad word, flipped in the generator or corrupted on the loopback
  task automatic injectError(input bit useInsert);
    logic [DATA_WIDTH-1:0] mask;
    mask = $random(seed);
    mask[0] = mask[0] | (mask == '0);
    @(posedge clk);
    if (useInsert) insertError <= 1'b1;
    else corruptMask <= mask;
    @(posedge clk);
    insertError <= 1'b0;
    corruptMask <= '0;
    // the flipped word leaves the generator register one cycle after insertError
    if (useInsert) @(posedge clk);
    @(negedge clk);
    checkValue("errorFlag after bad word", 1, 32'(errorFlag));
    @(negedge clk);
    checkValue("errorFlag one cycle later", 0, 32'(errorFlag));
  endtask

  // four-phase readout, also reports how many falling edges each ack change took
  task automatic readCount(output logic [COUNT_WIDTH-1:0] value, output int riseWait,
                           output int fallWait);
    @(posedge clk);
    statReq <= 1'b1;
    riseWait = 0;
    do begin
      @(negedge clk);
      riseWait++;
    end while (!statAck && riseWait < WAIT_LIMIT);
    expectTrue(statAck, "statAck rising after statReq");
    value = statCount;
    @(posedge clk);
    statReq <= 1'b0;
    fallWait = 0;
    do begin
      @(negedge clk);
      fallWait++;
    end while (statAck && fallWait < WAIT_LIMIT);
    expectTrue(!statAck, "statAck falling after statReq");
  endtask

  // ----------------------------------------------------------------------
  // tests
  // ----------------------------------------------------------------------

  initial begin
    logic [COUNT_WIDTH-1:0] count;
    logic [DATA_WIDTH-1:0]  expWord;
    int                     words;
    int                     riseWait;
    int                     fallWait;

    nreset      = 1'b0;
    enable      = 1'b0;
    patternSel  = PAT7;
    pause       = 1'b0;
    insertError = 1'b0;
    corruptMask = '0;
    statReq     = 1'b0;
    repeat (3) @(posedge clk);
    nreset <= 1'b1;
    @(negedge clk);
    expectTrue(!lock && !errorFlag && !statAck, "lock, errorFlag and statAck low after reset");
    checkValue("statCount after reset", 0, 32'(statCount));

    beginTest("patterns");
    for (int p = 0; p < 4; p++) begin
      startLink(PAT_WIDTH'(p));
      expWord = SEED;
      for (int i = 0; i < PATTERN_WORDS; i++) begin
        expWord = prbsNext(expWord, PAT_WIDTH'(p));
        @(negedge clk);
        checkValue("next word", expWord, txData);
      end
    end
    endTest();

    // a random pattern, the link then stays locked for the rest of the run
    beginTest("lock");
    startLink(PAT_WIDTH'($random(seed)));
    words = 0;
    while (!lock && words < 2 * LOCK_WORDS) begin
      @(negedge clk);
      words++;
      expectTrue(!errorFlag, "errorFlag low before lock");
    end
    checkValue("words from seed to lock", LOCK_WORDS, words);
    endTest();

    beginTest("corruption");
    readCount(count, riseWait, fallWait);
    checkValue("count before errors", 0, 32'(count));
    for (int i = 0; i < ERROR_WORDS; i++) begin
      repeat (3 + ($random(seed) & 7)) @(posedge clk);
      injectError(1'b0);
    end
    readCount(count, riseWait, fallWait);
    checkValue("error count", ERROR_WORDS, 32'(count));
    endTest();

    beginTest("insertError");
    for (int i = 0; i < ERROR_WORDS; i++) begin
      repeat (3 + ($random(seed) & 7)) @(posedge clk);
      injectError(1'b1);
    end
    readCount(count, riseWait, fallWait);
    checkValue("error count", ERROR_WORDS, 32'(count));
    endTest();

    // txData holding still through a pause is covered by the model compare
    beginTest("pause");
    for (int i = 0; i < PAUSE_CYCLES; i++) begin
      @(posedge clk);
      pause <= (($random(seed) & 3) == 0);
      @(negedge clk);
      expectTrue(lock && !errorFlag, "lock high and errorFlag low");
    end
    @(posedge clk);
    pause <= 1'b0;
    readCount(count, riseWait, fallWait);
    checkValue("error count after pauses", 0, 32'(count));
    endTest();

    beginTest("readout");
    for (int i = 0; i < 3; i++) begin
      injectError(1'b0);
    end
    readCount(count, riseWait, fallWait);
    checkValue("error count", 3, 32'(count));
    checkValue("edges until ack rises", 2, riseWait);
    checkValue("edges until ack falls", 2, fallWait);
    readCount(count, riseWait, fallWait);
    checkValue("count after clear", 0, 32'(count));
    // the flipped word raises errorFlag in the cycle that takes the snapshot,
    // so that error opens the next interval
    @(posedge clk);
    insertError <= 1'b1;
    @(posedge clk);
    insertError <= 1'b0;
    readCount(count, riseWait, fallWait);
    checkValue("count at snapshot with error", 0, 32'(count));
    readCount(count, riseWait, fallWait);
    checkValue("error from snapshot cycle", 1, 32'(count));
    endTest();

    $display("tests run %0d, tests with errors %0d, failed checks %0d",
             testsRun, testsFailed, errorCount);
    if (errorCount == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

// File: verif/prbsTb_checker.sv
`timescale 1ns/1ps

module prbsTb_checker (
  input logic clk,
  input logic nreset,
  input logic enable,
  input logic lock,
  input logic errorFlag,
  input logic statReq,
  input logic statAck
);

  // ----------------------------------------------------------------------
  // readout handshake
  // ----------------------------------------------------------------------

  // ack only rises in answer to a request that was pending at the edge before
  ackRiseNeedsReq: assert property (@(posedge clk) disable iff (!nreset)
    $rose(statAck) |-> $past(statReq))
    else $error("statAck rose while statReq was low");

  // a pending request is answered on the very next edge
  reqAnswered: assert property (@(posedge clk) disable iff (!nreset)
    statReq && !statAck |=> statAck)
    else $error("statAck did not answer statReq on the next edge");

  // ack holds as long as the host keeps req up, and drops only after req has dropped
  ackFallAfterReq: assert property (@(posedge clk) disable iff (!nreset)
    $fell(statAck) |-> !$past(statReq))
    else $error("statAck fell before statReq fell");

  // ----------------------------------------------------------------------
  // lock behavior
  // ----------------------------------------------------------------------

  // errors are only flagged against a locked prediction
  flagNeedsLock: assert property (@(posedge clk) disable iff (!nreset)
    errorFlag |-> lock)
    else $error("errorFlag high while lock is low");

  // Only disable can take the checker out of lock.
  lockHolds: assert property (@(posedge clk) disable iff (!nreset)
    lock && enable |=> lock)
    else $error("lock dropped while the link stayed enabled");

endmodule
